//--- Makefile
# Verilator build and run for the AXI4-Lite RAM testbench
# any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_axil_ram
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
EXTRA     ?=

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS EXTRA"

# the simulator exits non-zero on any $$fatal, so make fails with it
test:
	$(VERILATOR) $(VFLAGS) $(EXTRA) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- axil_ram/axil_ram_ctrl.sv
// AXI4-Lite RAM controller
// holds off the bus during the clear sweep, then serializes write and
// read transactions onto the single storage port with alternating
// priority, decodes out-of-range addresses to DECERR
`default_nettype none

`include "ram_defs.svh"

module axil_ram_ctrl (
   input  logic                       clk,
   input  logic                       rst,
   input  axil_pkg::axil_aw_t         aw,
   input  logic                       aw_valid,
   output logic                       aw_ready,
   input  axil_pkg::axil_w_t          w,
   input  logic                       w_valid,
   output logic                       w_ready,
   output axil_pkg::axil_b_t          b,
   output logic                       b_valid,
   input  logic                       b_ready,
   input  axil_pkg::axil_ar_t         ar,
   input  logic                       ar_valid,
   output logic                       ar_ready,
   output axil_pkg::axil_r_t          r,
   output logic                       r_valid,
   input  logic                       r_ready,
   input  ram_pkg::ram_req_t          init_req,
   input  logic                       init_done,
   output ram_pkg::ram_req_t          mem_req,
   input  logic [`RAM_DATA_WIDTH-1:0] rd_data
);
   import axil_pkg::*;
   import ram_pkg::*;

   ctrl_state_t state;
   // set when the last served transaction was a write
   logic        last_wr;
   axil_resp_t  b_resp_q;
   axil_resp_t  r_resp_q;
   ram_addr_u   aw_dec;
   ram_addr_u   ar_dec;
   logic        wr_pending;
   logic        rd_pending;
   logic        wr_grant;
   logic        rd_grant;
   logic        wr_in_range;
   logic        rd_in_range;
   ram_req_t    own_req;

   assign aw_dec.raw = aw.addr;
   assign ar_dec.raw = ar.addr;

   // anything above the implemented words decodes to DECERR
   assign wr_in_range = (aw_dec.field.upper == '0);
   assign rd_in_range = (ar_dec.field.upper == '0);

   // a write needs both address and data present
   assign wr_pending = aw_valid && w_valid;
   assign rd_pending = ar_valid;

   // write goes first unless it was served last and a read waits
   assign wr_grant = (state == IDLE) && wr_pending && (!rd_pending || !last_wr);
   assign rd_grant = (state == IDLE) && rd_pending && !wr_grant;

   // single-cycle ready pulse on the accept cycle
   assign aw_ready = wr_grant;
   assign w_ready  = wr_grant;
   assign ar_ready = rd_grant;

   // storage request for the accepted transaction
   always_comb begin
      own_req = '0;
      if (wr_grant) begin
         // DECERR writes touch no memory
         own_req.wr_en = wr_in_range;
         own_req.index = aw_dec.field.index;
         own_req.data  = w.data;
         own_req.strb  = w.strb;
      end else if (rd_grant) begin
         own_req.rd_en = rd_in_range;
         own_req.index = ar_dec.field.index;
      end
   end

   // clear sweep owns the storage port until done
   assign mem_req = init_done ? own_req : init_req;

   always_ff @(posedge clk) begin
      if (rst) begin
         state   <= INIT;
         // read counts as last served, so writes win first
         last_wr <= 1'b0;
      end else begin
         case (state)
            INIT: begin
               if (init_done) begin
                  state <= IDLE;
               end
            end
            IDLE: begin
               if (wr_grant) begin
                  state   <= WRITE_RESP;
                  last_wr <= 1'b1;
               end else if (rd_grant) begin
                  state   <= READ_RESP;
                  last_wr <= 1'b0;
               end
            end
            WRITE_RESP: begin
               if (b_ready) begin
                  state <= IDLE;
               end
            end
            READ_RESP: begin
               if (r_ready) begin
                  state <= IDLE;
               end
            end
            default: state <= INIT;
         endcase
      end
   end

   // response codes, captured on accept
   always_ff @(posedge clk) begin
      if (wr_grant) begin
         b_resp_q <= wr_in_range ? OKAY : DECERR;
      end
      if (rd_grant) begin
         r_resp_q <= rd_in_range ? OKAY : DECERR;
      end
   end

   assign b_valid = (state == WRITE_RESP);
   assign b.resp  = b_resp_q;

   // storage holds rd_data until the next read request, none come in READ_RESP
   assign r_valid = (state == READ_RESP);
   assign r.resp  = r_resp_q;
   assign r.data  = (r_resp_q == DECERR) ? '0 : rd_data;

   // one response channel at a time
   a_one_resp: assert property (@(posedge clk) disable iff (rst)
      !(b_valid && r_valid));

   // bus stays closed during the clear sweep
   a_no_ready_init: assert property (@(posedge clk) disable iff (rst)
      (state == INIT) |-> !(aw_ready || w_ready || ar_ready));

   // responses hold under back-pressure
   a_b_stable: assert property (@(posedge clk) disable iff (rst)
      (b_valid && !b_ready) |=> (b_valid && $stable(b)));

   a_r_stable: assert property (@(posedge clk) disable iff (rst)
      (r_valid && !r_ready) |=> (r_valid && $stable(r)));

endmodule

`default_nettype wire

//--- axil_ram/axil_ram_top.sv
// AXI4-Lite slave RAM, top level
// groups the AXI ports into channel structs and ties together
// the controller, the reset clear sweep and the word storage
`default_nettype none

`include "ram_defs.svh"

module axil_ram_top (
   input  logic                       clk,
   input  logic                       rst,

   // debug backdoor
   input  logic [`RAM_WORD_BITS-1:0]  debug_addr,
   output logic [`RAM_DATA_WIDTH-1:0] debug_data,
   input  logic [`RAM_WORD_BITS-1:0]  debug_wr_addr,
   input  logic [`RAM_DATA_WIDTH-1:0] debug_wr_data,
   input  logic                       debug_wr_en,

   // write address
   input  logic [`RAM_ADDR_WIDTH-1:0] s_axil_awaddr,
   input  logic [2:0]                 s_axil_awprot,
   input  logic                       s_axil_awvalid,
   output logic                       s_axil_awready,

   // write data
   input  logic [`RAM_DATA_WIDTH-1:0] s_axil_wdata,
   input  logic [`RAM_STRB_WIDTH-1:0] s_axil_wstrb,
   input  logic                       s_axil_wvalid,
   output logic                       s_axil_wready,

   // write response
   output logic [1:0]                 s_axil_bresp,
   output logic                       s_axil_bvalid,
   input  logic                       s_axil_bready,

   // read address
   input  logic [`RAM_ADDR_WIDTH-1:0] s_axil_araddr,
   input  logic [2:0]                 s_axil_arprot,
   input  logic                       s_axil_arvalid,
   output logic                       s_axil_arready,

   // read data
   output logic [`RAM_DATA_WIDTH-1:0] s_axil_rdata,
   output logic [1:0]                 s_axil_rresp,
   output logic                       s_axil_rvalid,
   input  logic                       s_axil_rready
);
   import axil_pkg::*;
   import ram_pkg::*;

   axil_aw_t                   aw;
   axil_w_t                    w;
   axil_b_t                    b;
   axil_ar_t                   ar;
   axil_r_t                    r;
   ram_req_t                   init_req;
   ram_req_t                   mem_req;
   logic                       init_done;
   logic [`RAM_DATA_WIDTH-1:0] rd_data;

   // port bundling
   assign aw = '{addr: s_axil_awaddr, prot: s_axil_awprot};
   assign w  = '{data: s_axil_wdata, strb: s_axil_wstrb};
   assign ar = '{addr: s_axil_araddr, prot: s_axil_arprot};

   assign s_axil_bresp = b.resp;
   assign s_axil_rdata = r.data;
   assign s_axil_rresp = r.resp;

   axil_ram_ctrl u_ctrl (
      .clk       (clk),
      .rst       (rst),
      .aw        (aw),
      .aw_valid  (s_axil_awvalid),
      .aw_ready  (s_axil_awready),
      .w         (w),
      .w_valid   (s_axil_wvalid),
      .w_ready   (s_axil_wready),
      .b         (b),
      .b_valid   (s_axil_bvalid),
      .b_ready   (s_axil_bready),
      .ar        (ar),
      .ar_valid  (s_axil_arvalid),
      .ar_ready  (s_axil_arready),
      .r         (r),
      .r_valid   (s_axil_rvalid),
      .r_ready   (s_axil_rready),
      .init_req  (init_req),
      .init_done (init_done),
      .mem_req   (mem_req),
      .rd_data   (rd_data)
   );

   ram_init_counter u_init (
      .clk       (clk),
      .rst       (rst),
      .init_req  (init_req),
      .init_done (init_done)
   );

   ram_store u_store (
      .clk           (clk),
      .req           (mem_req),
      .rd_data       (rd_data),
      .debug_addr    (debug_addr),
      .debug_data    (debug_data),
      .debug_wr_addr (debug_wr_addr),
      .debug_wr_data (debug_wr_data),
      .debug_wr_en   (debug_wr_en)
   );

endmodule

`default_nettype wire

//--- axil_ram/ram_init_counter.sv
// RAM clear sequencer
// after reset writes zero to every word, one per cycle,
// then holds init_done until the next reset
`default_nettype none

`include "ram_defs.svh"

module ram_init_counter (
   input  logic              clk,
   input  logic              rst,
   output ram_pkg::ram_req_t init_req,
   output logic              init_done
);

   logic [`RAM_WORD_BITS-1:0] count;
   logic                      done;

   always_ff @(posedge clk) begin
      if (rst) begin
         count <= '0;
         done  <= 1'b0;
      end else if (!done) begin
         // last word goes out this cycle
         if (count == `RAM_WORD_BITS'(`RAM_WORDS - 1)) begin
            done <= 1'b1;
         end else begin
            count <= count + 1'b1;
         end
      end
   end

   // full-strobe zero write at the current index
   always_comb begin
      init_req       = '0;
      init_req.wr_en = !done;
      init_req.index = count;
      init_req.strb  = '1;
   end

   assign init_done = done;

   // index frozen once the sweep is over
   a_hold_after_done: assert property (@(posedge clk) disable iff (rst)
      done |=> (done && $stable(count)));

endmodule

`default_nettype wire

//--- axil_ram/ram_store.sv
// RAM word storage
// byte-strobed AXI-side write and registered read,
// plus a debug port with combinational read and its own write
`default_nettype none

`include "ram_defs.svh"

module ram_store (
   input  logic                       clk,
   input  ram_pkg::ram_req_t          req,
   output logic [`RAM_DATA_WIDTH-1:0] rd_data,
   input  logic [`RAM_WORD_BITS-1:0]  debug_addr,
   output logic [`RAM_DATA_WIDTH-1:0] debug_data,
   input  logic [`RAM_WORD_BITS-1:0]  debug_wr_addr,
   input  logic [`RAM_DATA_WIDTH-1:0] debug_wr_data,
   input  logic                       debug_wr_en
);

   logic [`RAM_DATA_WIDTH-1:0] mem [`RAM_WORDS];

   always_ff @(posedge clk) begin
      if (req.wr_en) begin
         for (int i = 0; i < `RAM_STRB_WIDTH; i++) begin
            if (req.strb[i]) begin
               mem[req.index][8*i +: 8] <= req.data[8*i +: 8];
            end
         end
      end
      // debug write comes later, so it wins a same-word collision
      if (debug_wr_en) begin
         mem[debug_wr_addr] <= debug_wr_data;
      end
   end

   // held between read requests
   always_ff @(posedge clk) begin
      if (req.rd_en) begin
         rd_data <= mem[req.index];
      end
   end

   // backdoor read, no clock
   assign debug_data = mem[debug_addr];

endmodule

`default_nettype wire

//--- common/axil_pkg.sv
// AXI4-Lite channel types
// one struct per channel payload, valid/ready stay separate
`default_nettype none

`include "ram_defs.svh"

package axil_pkg;

   // only the two codes this slave can return
   typedef enum logic [1:0] {
      OKAY   = 2'b00,
      DECERR = 2'b11
   } axil_resp_t;

   // write address channel
   typedef struct packed {
      logic [`RAM_ADDR_WIDTH-1:0] addr;
      logic [2:0]                 prot;
   } axil_aw_t;

   // write data channel
   typedef struct packed {
      logic [`RAM_DATA_WIDTH-1:0] data;
      logic [`RAM_STRB_WIDTH-1:0] strb;
   } axil_w_t;

   // write response channel
   typedef struct packed {
      axil_resp_t resp;
   } axil_b_t;

   // read address channel
   typedef struct packed {
      logic [`RAM_ADDR_WIDTH-1:0] addr;
      logic [2:0]                 prot;
   } axil_ar_t;

   // read data channel
   typedef struct packed {
      logic [`RAM_DATA_WIDTH-1:0] data;
      axil_resp_t                 resp;
   } axil_r_t;

endpackage

`default_nettype wire

//--- common/ram_defs.svh
// AXI4-Lite RAM sizing
// bus widths and implemented depth, shared by the packages and RTL
`ifndef RAM_DEFS_SVH
`define RAM_DEFS_SVH

// bus and storage word width in bits
`define RAM_DATA_WIDTH 32

// AXI byte address width
`define RAM_ADDR_WIDTH 16

// implemented words, power of two
`define RAM_WORDS 256

// word index width
`define RAM_WORD_BITS $clog2(`RAM_WORDS)

// one strobe bit per data byte
`define RAM_STRB_WIDTH (`RAM_DATA_WIDTH / 8)

// byte offset bits inside a word
`define RAM_BYTE_BITS $clog2(`RAM_STRB_WIDTH)

// address bits above the implemented range
`define RAM_UPPER_BITS (`RAM_ADDR_WIDTH - `RAM_WORD_BITS - `RAM_BYTE_BITS)

`endif

//--- common/ram_pkg.sv
// memory-side types for the AXI4-Lite RAM
// address decode view, storage request, controller states
`default_nettype none

`include "ram_defs.svh"

package ram_pkg;

   // one byte address, seen raw or split into fields
   typedef union packed {
      logic [`RAM_ADDR_WIDTH-1:0] raw;
      struct packed {
         // nonzero means outside the implemented depth
         logic [`RAM_UPPER_BITS-1:0] upper;
         logic [`RAM_WORD_BITS-1:0]  index;
         logic [`RAM_BYTE_BITS-1:0]  offset;
      } field;
   } ram_addr_u;

   // AXI-side storage access, at most one of wr_en/rd_en
   typedef struct packed {
      logic                       wr_en;
      logic                       rd_en;
      logic [`RAM_WORD_BITS-1:0]  index;
      logic [`RAM_DATA_WIDTH-1:0] data;
      logic [`RAM_STRB_WIDTH-1:0] strb;
   } ram_req_t;

   typedef enum logic [1:0] {
      INIT,
      IDLE,
      WRITE_RESP,
      READ_RESP
   } ctrl_state_t;

endpackage

`default_nettype wire

//--- compile.f
+incdir+common
common/axil_pkg.sv
common/ram_pkg.sv
axil_ram/ram_store.sv
axil_ram/ram_init_counter.sv
axil_ram/axil_ram_ctrl.sv
axil_ram/axil_ram_top.sv
verification/tb_axil_ram.sv

//--- verification/tb_axil_ram.sv
// testbench for the AXI4-Lite slave RAM
// random AXI and debug traffic, checked against a word model
// that applies the clear, strobe, DECERR and arbitration rules
`default_nettype none

`include "ram_defs.svh"

module tb_axil_ram;
   import axil_pkg::*;
   import ram_pkg::*;

   localparam int CLK_PERIOD = 40;
   localparam int WORD_BITS  = `RAM_WORD_BITS;
   localparam int UPPER_BITS = `RAM_UPPER_BITS;
   // a small window of words so reads hit earlier writes
   localparam int SPAN       = 16;
   localparam int N_INIT     = 8;
   localparam int N_RAND     = 40;
   localparam int N_ERR      = 8;
   localparam int N_PAIR     = 20;
   localparam int N_DEBUG    = 8;
   localparam int N_TXN      = N_INIT + 2 * N_RAND + 3 * N_ERR + 3 * N_PAIR + 4 * N_DEBUG;
   localparam int TIMEOUT_CYCLES = `RAM_WORDS + 40 * N_TXN;

   logic                       clk;
   logic                       rst;
   logic [WORD_BITS-1:0]       debug_addr;
   logic [`RAM_DATA_WIDTH-1:0] debug_data;
   logic [WORD_BITS-1:0]       debug_wr_addr;
   logic [`RAM_DATA_WIDTH-1:0] debug_wr_data;
   logic                       debug_wr_en;
   logic [`RAM_ADDR_WIDTH-1:0] s_axil_awaddr;
   logic [2:0]                 s_axil_awprot;
   logic                       s_axil_awvalid;
   logic                       s_axil_awready;
   logic [`RAM_DATA_WIDTH-1:0] s_axil_wdata;
   logic [`RAM_STRB_WIDTH-1:0] s_axil_wstrb;
   logic                       s_axil_wvalid;
   logic                       s_axil_wready;
   logic [1:0]                 s_axil_bresp;
   logic                       s_axil_bvalid;
   logic                       s_axil_bready;
   logic [`RAM_ADDR_WIDTH-1:0] s_axil_araddr;
   logic [2:0]                 s_axil_arprot;
   logic                       s_axil_arvalid;
   logic                       s_axil_arready;
   logic [`RAM_DATA_WIDTH-1:0] s_axil_rdata;
   logic [1:0]                 s_axil_rresp;
   logic                       s_axil_rvalid;
   logic                       s_axil_rready;

   // reference memory and arbitration state
   logic [`RAM_DATA_WIDTH-1:0] model_mem [`RAM_WORDS];
   logic                       last_was_write;
   integer                     seed;
   int                         init_cycles;

   axil_ram_top u_axil_ram_top (
      .clk            (clk),
      .rst            (rst),
      .debug_addr     (debug_addr),
      .debug_data     (debug_data),
      .debug_wr_addr  (debug_wr_addr),
      .debug_wr_data  (debug_wr_data),
      .debug_wr_en    (debug_wr_en),
      .s_axil_awaddr  (s_axil_awaddr),
      .s_axil_awprot  (s_axil_awprot),
      .s_axil_awvalid (s_axil_awvalid),
      .s_axil_awready (s_axil_awready),
      .s_axil_wdata   (s_axil_wdata),
      .s_axil_wstrb   (s_axil_wstrb),
      .s_axil_wvalid  (s_axil_wvalid),
      .s_axil_wready  (s_axil_wready),
      .s_axil_bresp   (s_axil_bresp),
      .s_axil_bvalid  (s_axil_bvalid),
      .s_axil_bready  (s_axil_bready),
      .s_axil_araddr  (s_axil_araddr),
      .s_axil_arprot  (s_axil_arprot),
      .s_axil_arvalid (s_axil_arvalid),
      .s_axil_arready (s_axil_arready),
      .s_axil_rdata   (s_axil_rdata),
      .s_axil_rresp   (s_axil_rresp),
      .s_axil_rvalid  (s_axil_rvalid),
      .s_axil_rready  (s_axil_rready)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial begin
      #(TIMEOUT_CYCLES * CLK_PERIOD);
      $display("timeout: run did not finish within %0d clock periods", TIMEOUT_CYCLES);
      $display("*** FAILED ***");
      $fatal(1, "watchdog expired");
   end

   task automatic compare_value(input logic [31:0] actual, input logic [31:0] expected,
                                input string what);
      if (actual !== expected) begin
         $display("FAILED at %0t: %s, got %h expected %h", $time, what, actual, expected);
         $display("*** FAILED ***");
         $fatal(1, "value mismatch");
      end
   endtask

   function automatic logic [31:0] rand_word();
      return $random(seed);
   endfunction

   function automatic int rand_below(input int n);
      logic [31:0] r;
      r = rand_word();
      return int'(r % 32'(n));
   endfunction

   // in-range or out-of-range byte address, word index below span
   function automatic logic [`RAM_ADDR_WIDTH-1:0] make_addr(input int span, input logic outside);
      ram_addr_u   dec;
      logic [31:0] r;
      r = rand_word();
      dec.raw = r[`RAM_ADDR_WIDTH-1:0];
      r = 32'(rand_below(span));
      dec.field.index = r[WORD_BITS-1:0];
      if (!outside) begin
         dec.field.upper = '0;
      end else if (dec.field.upper == '0) begin
         dec.field.upper = UPPER_BITS'(1);
      end
      return dec.raw;
   endfunction

   // strobed write into the model, DECERR leaves it alone
   function automatic logic [1:0] model_write(input logic [`RAM_ADDR_WIDTH-1:0] addr,
                                              input logic [`RAM_DATA_WIDTH-1:0] data,
                                              input logic [`RAM_STRB_WIDTH-1:0] strb);
      ram_addr_u dec;
      integer    i;
      dec.raw = addr;
      if (dec.field.upper != '0) begin
         return DECERR;
      end
      for (i = 0; i < `RAM_STRB_WIDTH; i++) begin
         if (strb[i]) begin
            model_mem[dec.field.index][8*i +: 8] = data[8*i +: 8];
         end
      end
      return OKAY;
   endfunction

   task automatic model_read(input logic [`RAM_ADDR_WIDTH-1:0] addr,
                             output logic [`RAM_DATA_WIDTH-1:0] data, output logic [1:0] resp);
      ram_addr_u dec;
      dec.raw = addr;
      if (dec.field.upper != '0) begin
         data = '0;
         resp = DECERR;
      end else begin
         data = model_mem[dec.field.index];
         resp = OKAY;
      end
   endtask

   // one write, one read or both, with random valid delay and back-pressure
   task automatic run_txn(input logic do_wr, input logic do_rd,
                          input logic [`RAM_ADDR_WIDTH-1:0] waddr,
                          input logic [`RAM_DATA_WIDTH-1:0] wdata,
                          input logic [`RAM_STRB_WIDTH-1:0] wstrb,
                          input logic [`RAM_ADDR_WIDTH-1:0] raddr, input logic same_start);
      int                         wr_dly;
      int                         rd_dly;
      logic                       wr_todo;
      logic                       rd_todo;
      logic                       wr_on;
      logic                       rd_on;
      logic                       b_wait;
      logic                       r_wait;
      logic                       wr_pend;
      logic                       rd_pend;
      logic [1:0]                 exp_bresp;
      logic [1:0]                 exp_rresp;
      logic [`RAM_DATA_WIDTH-1:0] exp_rdata;
      logic [31:0]                rnd;
      wr_dly    = same_start ? 0 : rand_below(4);
      rd_dly    = same_start ? 0 : rand_below(4);
      wr_todo   = do_wr;
      rd_todo   = do_rd;
      wr_on     = 1'b0;
      rd_on     = 1'b0;
      b_wait    = 1'b0;
      r_wait    = 1'b0;
      exp_bresp = OKAY;
      exp_rresp = OKAY;
      exp_rdata = '0;
      while (wr_todo || rd_todo || b_wait || r_wait) begin
         @(posedge clk);
         wr_pend = s_axil_awvalid && s_axil_wvalid;
         rd_pend = s_axil_arvalid;
         // responses must match the fixed expectation every cycle they are held
         if (s_axil_bvalid) begin
            compare_value(32'(b_wait), 32'd1, "B response with no write outstanding");
            compare_value(32'(s_axil_bresp), 32'(exp_bresp), "bresp");
            if (s_axil_bready) begin
               b_wait = 1'b0;
            end
         end
         if (s_axil_rvalid) begin
            compare_value(32'(r_wait), 32'd1, "R response with no read outstanding");
            compare_value(32'(s_axil_rresp), 32'(exp_rresp), "rresp");
            compare_value(s_axil_rdata, exp_rdata, "rdata");
            if (s_axil_rready) begin
               r_wait = 1'b0;
            end
         end
         if (s_axil_awready) begin
            compare_value(32'(wr_pend), 32'd1, "awready without a pending write");
            // both pending, the side not served last wins
            if (rd_pend) begin
               compare_value(32'(last_was_write), 32'd0, "write granted out of turn");
            end
            exp_bresp = model_write(waddr, wdata, wstrb);
            // same-cycle debug write lands on top
            if (debug_wr_en) begin
               model_mem[debug_wr_addr] = debug_wr_data;
               debug_wr_en <= 1'b0;
            end
            last_was_write = 1'b1;
            wr_todo        = 1'b0;
            b_wait         = 1'b1;
            s_axil_awvalid <= 1'b0;
            s_axil_wvalid  <= 1'b0;
         end
         if (s_axil_arready) begin
            compare_value(32'(rd_pend), 32'd1, "arready without a pending read");
            if (wr_pend) begin
               compare_value(32'(last_was_write), 32'd1, "read granted out of turn");
            end
            model_read(raddr, exp_rdata, exp_rresp);
            last_was_write = 1'b0;
            rd_todo        = 1'b0;
            r_wait         = 1'b1;
            s_axil_arvalid <= 1'b0;
         end
         if (wr_todo && !wr_on) begin
            if (wr_dly == 0) begin
               rnd = rand_word();
               s_axil_awaddr  <= waddr;
               s_axil_awprot  <= rnd[2:0];
               s_axil_wdata   <= wdata;
               s_axil_wstrb   <= wstrb;
               s_axil_awvalid <= 1'b1;
               s_axil_wvalid  <= 1'b1;
               wr_on = 1'b1;
            end else begin
               wr_dly = wr_dly - 1;
            end
         end
         if (rd_todo && !rd_on) begin
            if (rd_dly == 0) begin
               rnd = rand_word();
               s_axil_araddr  <= raddr;
               s_axil_arprot  <= rnd[2:0];
               s_axil_arvalid <= 1'b1;
               rd_on = 1'b1;
            end else begin
               rd_dly = rd_dly - 1;
            end
         end
         // ready high about three cycles out of four
         s_axil_bready <= (rand_below(4) != 0);
         s_axil_rready <= (rand_below(4) != 0);
      end
   endtask

   task automatic write_debug(input logic [WORD_BITS-1:0] idx,
                              input logic [`RAM_DATA_WIDTH-1:0] data);
      debug_wr_addr <= idx;
      debug_wr_data <= data;
      debug_wr_en   <= 1'b1;
      @(posedge clk);
      model_mem[idx] = data;
      debug_wr_en <= 1'b0;
   endtask

   task automatic check_debug_read(input logic [WORD_BITS-1:0] idx);
      debug_addr <= idx;
      @(posedge clk);
      compare_value(debug_data, model_mem[idx], "debug_data");
   endtask

   // bus stays shut for the clear sweep, AW and W accepted as a pair
   always @(posedge clk) begin
      if (rst) begin
         init_cycles <= 0;
      end else begin
         compare_value(32'(s_axil_awready), 32'(s_axil_wready), "awready and wready differ");
         compare_value(32'(s_axil_awready && s_axil_arready), 32'd0,
                       "write and read accepted in one cycle");
         if (init_cycles < `RAM_WORDS) begin
            compare_value(32'(s_axil_awready || s_axil_arready || s_axil_bvalid ||
                              s_axil_rvalid), 32'd0, "handshake output high during clear");
            init_cycles <= init_cycles + 1;
         end
      end
   end

   initial begin
      ram_addr_u                  dec;
      logic [`RAM_ADDR_WIDTH-1:0] waddr;
      logic [31:0]                rnd;
      integer                     n;
      seed = 32'h380434f7;
      rst            <= 1'b1;
      debug_addr     <= '0;
      debug_wr_addr  <= '0;
      debug_wr_data  <= '0;
      debug_wr_en    <= 1'b0;
      s_axil_awaddr  <= '0;
      s_axil_awprot  <= '0;
      s_axil_awvalid <= 1'b0;
      s_axil_wdata   <= '0;
      s_axil_wstrb   <= '0;
      s_axil_wvalid  <= 1'b0;
      s_axil_bready  <= 1'b0;
      s_axil_araddr  <= '0;
      s_axil_arprot  <= '0;
      s_axil_arvalid <= 1'b0;
      s_axil_rready  <= 1'b0;
      // model starts cleared, reads counted as last served
      for (n = 0; n < `RAM_WORDS; n++) begin
         model_mem[n] = '0;
      end
      last_was_write = 1'b0;
      repeat (5) @(posedge clk);
      rst <= 1'b0;

      // cleared words, over AXI and the backdoor
      for (n = 0; n < N_INIT; n++) begin
         run_txn(1'b0, 1'b1, '0, '0, '0, make_addr(`RAM_WORDS, 1'b0), 1'b0);
         rnd = rand_word();
         check_debug_read(rnd[WORD_BITS-1:0]);
      end

      // random strobed writes and reads
      for (n = 0; n < N_RAND; n++) begin
         rnd = rand_word();
         run_txn(1'b1, 1'b0, make_addr(SPAN, 1'b0), rand_word(), rnd[`RAM_STRB_WIDTH-1:0],
                 '0, 1'b0);
         run_txn(1'b0, 1'b1, '0, '0, '0, make_addr(SPAN, 1'b0), 1'b0);
      end

      // out-of-range write and read, then the aliased word is unchanged
      for (n = 0; n < N_ERR; n++) begin
         waddr = make_addr(SPAN, 1'b1);
         run_txn(1'b1, 1'b0, waddr, rand_word(), '1, '0, 1'b0);
         run_txn(1'b0, 1'b1, '0, '0, '0, waddr, 1'b0);
         dec.raw = waddr;
         dec.field.upper = '0;
         run_txn(1'b0, 1'b1, '0, '0, '0, dec.raw, 1'b0);
      end

      // write and read on one word at once
      // a lone write or read just before picks whose turn it is
      for (n = 0; n < N_PAIR; n++) begin
         if (rand_below(2) != 0) begin
            run_txn(1'b1, 1'b0, make_addr(SPAN, 1'b0), rand_word(), '1, '0, 1'b0);
         end else begin
            run_txn(1'b0, 1'b1, '0, '0, '0, make_addr(SPAN, 1'b0), 1'b0);
         end
         waddr = make_addr(SPAN, 1'b0);
         rnd = rand_word();
         run_txn(1'b1, 1'b1, waddr, rand_word(), rnd[`RAM_STRB_WIDTH-1:0], waddr, 1'b1);
      end

      // backdoor against the bus, then a same-word collision
      for (n = 0; n < N_DEBUG; n++) begin
         waddr = make_addr(SPAN, 1'b0);
         dec.raw = waddr;
         write_debug(dec.field.index, rand_word());
         run_txn(1'b0, 1'b1, '0, '0, '0, waddr, 1'b0);
         waddr = make_addr(SPAN, 1'b0);
         rnd = rand_word();
         run_txn(1'b1, 1'b0, waddr, rand_word(), rnd[`RAM_STRB_WIDTH-1:0], '0, 1'b0);
         dec.raw = waddr;
         check_debug_read(dec.field.index);
         waddr = make_addr(SPAN, 1'b0);
         dec.raw = waddr;
         debug_wr_addr <= dec.field.index;
         debug_wr_data <= rand_word();
         debug_wr_en   <= 1'b1;
         run_txn(1'b1, 1'b0, waddr, rand_word(), '1, '0, 1'b1);
         check_debug_read(dec.field.index);
         run_txn(1'b0, 1'b1, '0, '0, '0, waddr, 1'b0);
      end

      // no stray responses once traffic stops
      repeat (4) begin
         @(posedge clk);
         compare_value(32'(s_axil_bvalid || s_axil_rvalid), 32'd0, "response after idle");
      end
      $display("*** PASSED ***");
      $finish;
   end

endmodule

`default_nettype wire
